// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fsync_node
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= SIMULATION PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/fsync_node_chk.sv ====
`timescale 1ns/1ps

module fsync_node_chk (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         rsp_valid_i,
  input logic                         up_req_valid_i,
  input logic [fsync_pkg::AGGR_W-1:0] up_req_aggr_i,
  input logic                         error_i
);

  // counts failed properties so the testbench can see them at the end of the run.
  int unsigned fail_count = 0;

  // nothing leaves the node while it is held in reset.
  no_strobe_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!rsp_valid_i && !up_req_valid_i))
    else begin
      fail_count++;
      $error("output strobe while reset is asserted");
    end

  // a forwarded request always carries work for the parent.
  up_aggr_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    up_req_valid_i |-> (up_req_aggr_i != '0))
    else begin
      fail_count++;
      $error("parent request with a zero aggregate mask");
    end

  // the error flag is sticky until the next reset.
  error_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    error_i |=> error_i)
    else begin
      fail_count++;
      $error("error flag fell without a reset");
    end

endmodule

// ==== bench/tb_fsync_node.sv ====
`timescale 1ns/1ps

module tb_fsync_node;

  localparam int AW      = fsync_pkg::AGGR_W;
  localparam int IW      = fsync_pkg::ID_W;
  localparam int TIMEOUT = 200;

  logic          clk_i = 1'b0;
  logic          rst_ni;
  logic          en_req_valid_i;
  logic [AW-1:0] en_req_aggr_i;
  logic [IW-1:0] en_req_id_i;
  logic          ws_req_valid_i;
  logic [AW-1:0] ws_req_aggr_i;
  logic [IW-1:0] ws_req_id_i;
  logic          up_rsp_valid_i;
  logic [IW-1:0] up_rsp_id_i;
  logic          up_req_valid_o;
  logic [AW-1:0] up_req_aggr_o;
  logic [IW-1:0] up_req_id_o;
  logic          rsp_valid_o;
  logic [IW-1:0] rsp_id_o;
  logic          error_o;

  // reference state: arrival bits per id (bit 0 en, bit 1 ws) and the expected outputs.
  logic [1:0]    ref_arrived [fsync_pkg::N_IDS];
  logic [AW-1:0] exp_up_aggr [fsync_pkg::N_IDS];
  logic [IW-1:0] exp_rsp_q [$];
  logic [IW-1:0] exp_up_q [$];
  logic [IW-1:0] parent_pending_q [$];
  logic [31:0]   lcg_state = 32'h895d_9b41;
  bit            compare_on;
  bit            expect_error;

  always #5 clk_i = ~clk_i;

  fsync_node u_fsync_node (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .en_req_valid_i (en_req_valid_i),
    .en_req_aggr_i  (en_req_aggr_i),
    .en_req_id_i    (en_req_id_i),
    .ws_req_valid_i (ws_req_valid_i),
    .ws_req_aggr_i  (ws_req_aggr_i),
    .ws_req_id_i    (ws_req_id_i),
    .up_rsp_valid_i (up_rsp_valid_i),
    .up_rsp_id_i    (up_rsp_id_i),
    .up_req_valid_o (up_req_valid_o),
    .up_req_aggr_o  (up_req_aggr_o),
    .up_req_id_o    (up_req_id_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_id_o       (rsp_id_o),
    .error_o        (error_o)
  );

  bind fsync_node fsync_node_chk u_chk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rsp_valid_i    (rsp_valid_o),
    .up_req_valid_i (up_req_valid_o),
    .up_req_aggr_i  (up_req_aggr_o),
    .error_i        (error_o)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // returns 1 for a faulty request, which the node must drop.
  function automatic bit model_arrival(input bit child, input logic [AW-1:0] aggr,
                                       input logic [IW-1:0] id);
    if (aggr == '0 || ref_arrived[id][child]) begin
      return 1'b1;
    end
    if (ref_arrived[id][!child]) begin
      ref_arrived[id] = 2'b00;
      if (aggr == AW'(1)) begin
        exp_rsp_q.push_back(id);
      end else begin
        exp_up_q.push_back(id);
        exp_up_aggr[id] = aggr >> 1;
      end
    end else begin
      ref_arrived[id][child] = 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic fail_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      fail_run();
    end
  endtask

  task automatic drive(input bit en_v, input logic [AW-1:0] en_aggr, input logic [IW-1:0] en_id,
                       input bit ws_v, input logic [AW-1:0] ws_aggr, input logic [IW-1:0] ws_id);
    @(negedge clk_i);
    en_req_valid_i = en_v;
    en_req_aggr_i  = en_aggr;
    en_req_id_i    = en_id;
    ws_req_valid_i = ws_v;
    ws_req_aggr_i  = ws_aggr;
    ws_req_id_i    = ws_id;
    if (compare_on && en_v) begin
      expect_error |= model_arrival(1'b0, en_aggr, en_id);
    end
    if (compare_on && ws_v) begin
      expect_error |= model_arrival(1'b1, ws_aggr, ws_id);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    en_req_valid_i = 1'b0;
    ws_req_valid_i = 1'b0;
    up_rsp_valid_i = 1'b0;
    for (int i = 0; i < fsync_pkg::N_IDS; i++) begin
      ref_arrived[i] = 2'b00;
    end
    exp_rsp_q.delete();
    exp_up_q.delete();
    parent_pending_q.delete();
    expect_error = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    compare_on = 1'b1;
  endtask

  task automatic wait_drained(input string what);
    int cycles;
    cycles = 0;
    while (exp_rsp_q.size() != 0 || exp_up_q.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout in %s: %0d responses and %0d parent requests never came out",
                 what, exp_rsp_q.size(), exp_up_q.size());
        fail_run();
      end
    end
  endtask

  task automatic wait_error(input string what);
    int cycles;
    cycles = 0;
    while (error_o !== 1'b1) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: the error flag never rose after %s", what);
        fail_run();
      end
    end
  endtask

  // the parent answers every forwarded request, one per cycle.
  task automatic answer_parent();
    logic [IW-1:0] id;
    while (parent_pending_q.size() != 0) begin
      id = parent_pending_q.pop_front();
      @(negedge clk_i);
      up_rsp_valid_i = 1'b1;
      up_rsp_id_i    = id;
      exp_rsp_q.push_back(id);
    end
    @(negedge clk_i);
    up_rsp_valid_i = 1'b0;
  endtask

  task automatic match_response(input logic [IW-1:0] id);
    int idx[$];
    idx = exp_rsp_q.find_first_index(x) with (x == id);
    check(idx.size(), 1, $sformatf("child response for id %0h is expected", id));
    exp_rsp_q.delete(idx[0]);
  endtask

  task automatic match_parent_request(input logic [IW-1:0] id, input logic [AW-1:0] aggr);
    int idx[$];
    idx = exp_up_q.find_first_index(x) with (x == id);
    check(idx.size(), 1, $sformatf("parent request for id %0h is expected", id));
    check(aggr, exp_up_aggr[id], $sformatf("parent request mask for id %0h", id));
    exp_up_q.delete(idx[0]);
    parent_pending_q.push_back(id);
  endtask

  // outputs are registered, so the values seen at the rising edge belong to the cycle before.
  always @(posedge clk_i) begin
    if (rst_ni && compare_on) begin
      if (rsp_valid_o) begin
        match_response(rsp_id_o);
      end
      if (up_req_valid_o) begin
        match_parent_request(up_req_id_o, up_req_aggr_o);
      end
    end
  end

  initial begin
    logic [31:0]   r;
    logic [IW-1:0] id;
    logic [AW-1:0] aggr;
    logic [IW-1:0] ids[$];
    logic [AW-1:0] id_aggr [fsync_pkg::N_IDS];
    bit            used [fsync_pkg::N_IDS];
    bit            en_v;
    bit            ws_v;
    int            en_pos;
    int            ws_pos;

    rst_ni = 1'b0;
    en_req_valid_i = 1'b0;
    en_req_aggr_i = '0;
    en_req_id_i = '0;
    ws_req_valid_i = 1'b0;
    ws_req_aggr_i = '0;
    ws_req_id_i = '0;
    up_rsp_valid_i = 1'b0;
    up_rsp_id_i = '0;
    compare_on = 1'b0;
    apply_reset();

    // quiet after reset with idle inputs.
    repeat (10) begin
      @(negedge clk_i);
      check(rsp_valid_o, 0, "child response after reset");
      check(up_req_valid_o, 0, "parent request after reset");
      check(error_o, 0, "error flag after reset");
    end

    // local barrier, both children in the same cycle.
    r = lcg_next();
    id = r[19:16];
    drive(1'b1, AW'(1), id, 1'b1, AW'(1), id);
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    wait_drained("local barrier");
    repeat (8) @(negedge clk_i);

    // remote barrier, then the parent answers it.
    r = lcg_next();
    id = r[19:16];
    aggr = AW'(2 + r[27:20] % 14);
    drive(1'b1, aggr, id, 1'b0, '0, '0);
    drive(1'b0, '0, '0, 1'b1, aggr, id);
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    wait_drained("remote barrier request");
    answer_parent();
    wait_drained("remote barrier response");
    repeat (8) @(negedge clk_i);

    // eight barriers with distinct ids; the ws side arrives in a rotated order.
    for (int i = 0; i < fsync_pkg::N_IDS; i++) begin
      used[i] = 1'b0;
    end
    while (ids.size() < 8) begin
      r = lcg_next();
      id = r[19:16];
      if (!used[id]) begin
        used[id] = 1'b1;
        ids.push_back(id);
        id_aggr[id] = r[20] ? AW'(1) : AW'(2 + r[31:24] % 14);
      end
    end
    en_pos = 0;
    ws_pos = 0;
    while (en_pos < 8 || ws_pos < 8) begin
      r = lcg_next();
      en_v = (en_pos < 8) && (r[17:16] == 2'b00);
      ws_v = (ws_pos < 8) && (r[19:18] == 2'b00);
      drive(en_v, id_aggr[ids[en_pos % 8]], ids[en_pos % 8],
            ws_v, id_aggr[ids[(ws_pos + 3) % 8]], ids[(ws_pos + 3) % 8]);
      en_pos += int'(en_v);
      ws_pos += int'(ws_v);
    end
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    wait_drained("interleaved barriers");
    answer_parent();
    wait_drained("interleaved parent responses");
    repeat (8) @(negedge clk_i);
    check(error_o, expect_error, "error flag after clean traffic");

    // second arrival from the same child for an open id.
    apply_reset();
    drive(1'b1, AW'(1), 4'h5, 1'b0, '0, '0);
    drive(1'b1, AW'(1), 4'h5, 1'b0, '0, '0);
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    wait_error("a repeated arrival");
    repeat (8) @(negedge clk_i);

    // zero aggregate mask.
    apply_reset();
    drive(1'b0, '0, '0, 1'b1, '0, 4'h9);
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    wait_error("a zero mask");
    repeat (8) @(negedge clk_i);

    // both children strobe every cycle, more than the arbiter can drain.
    apply_reset();
    compare_on = 1'b0;
    for (int i = 0; i < 16; i++) begin
      drive(1'b1, AW'(1), IW'(i), 1'b1, AW'(1), IW'(i));
    end
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    wait_error("an RX FIFO overflow");
    apply_reset();
    repeat (4) @(negedge clk_i);

    if (u_fsync_node.u_chk.fail_count != 0) begin
      $display("the bound checker saw %0d assertion failures", u_fsync_node.u_chk.fail_count);
      fail_run();
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// ==== compile.f ====
logic/fsync_pkg.sv
logic/fsync_rx.sv
logic/fsync_req_arb.sv
logic/fsync_barrier.sv
logic/fsync_rsp_merge.sv
logic/fsync_node.sv
bench/fsync_node_chk.sv
bench/tb_fsync_node.sv

// ==== logic/fsync_barrier.sv ====
`timescale 1ns/1ps

module fsync_barrier (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         valid_i,
  input  fsync_pkg::child_e            src_i,
  input  logic [fsync_pkg::AGGR_W-1:0] aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]   id_i,
  input  logic [1:0]                   rx_overflow_i,
  input  logic                         rsp_overflow_i,
  output logic                         up_req_valid_o,
  output logic [fsync_pkg::AGGR_W-1:0] up_req_aggr_o,
  output logic [fsync_pkg::ID_W-1:0]   up_req_id_o,
  output logic                         local_valid_o,
  output logic [fsync_pkg::ID_W-1:0]   local_id_o,
  output logic                         error_o
);

  // one arrival bit per child for every barrier id, indexed by child_e.
  logic [1:0]                   arrived_q [fsync_pkg::N_IDS];
  fsync_pkg::child_e            other;
  fsync_pkg::sync_kind_e        kind;
  logic                         own_seen;
  logic                         other_seen;
  logic                         fault;
  logic                         complete;
  logic                         up_req_valid_q;
  logic                         local_valid_q;
  logic                         error_q;
  logic [fsync_pkg::AGGR_W-1:0] up_req_aggr_q;
  logic [fsync_pkg::ID_W-1:0]   id_q;

  always_comb begin
    other      = (src_i == fsync_pkg::CHILD_EN) ? fsync_pkg::CHILD_WS : fsync_pkg::CHILD_EN;
    own_seen   = arrived_q[id_i][src_i];
    other_seen = arrived_q[id_i][other];
    // a zero mask or a second arrival from the same side is dropped as faulty.
    fault    = valid_i && ((aggr_i == '0) || own_seen);
    complete = valid_i && !fault && other_seen;
    kind     = (aggr_i == fsync_pkg::AGGR_LOCAL) ? fsync_pkg::SYNC_LOCAL : fsync_pkg::SYNC_REMOTE;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < fsync_pkg::N_IDS; i++) begin
        arrived_q[i] <= 2'b00;
      end
    end else if (complete) begin
      // the barrier is closed, so the id can be reused right away.
      arrived_q[id_i] <= 2'b00;
    end else if (valid_i && !fault) begin
      arrived_q[id_i][src_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_req_valid_q <= 1'b0;
      local_valid_q  <= 1'b0;
      error_q        <= 1'b0;
    end else begin
      up_req_valid_q <= complete && (kind == fsync_pkg::SYNC_REMOTE);
      local_valid_q  <= complete && (kind == fsync_pkg::SYNC_LOCAL);
      error_q        <= error_q | fault | (|rx_overflow_i) | rsp_overflow_i;
    end
  end

  // the parent sees the mask one level up, hence the shift.
  always_ff @(posedge clk_i) begin
    if (complete) begin
      up_req_aggr_q <= aggr_i >> 1;
      id_q          <= id_i;
    end
  end

  assign up_req_valid_o = up_req_valid_q;
  assign up_req_aggr_o  = up_req_aggr_q;
  assign up_req_id_o    = id_q;
  assign local_valid_o  = local_valid_q;
  assign local_id_o     = id_q;
  assign error_o        = error_q;

endmodule

// ==== logic/fsync_node.sv ====
`timescale 1ns/1ps

module fsync_node (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         en_req_valid_i,
  input  logic [fsync_pkg::AGGR_W-1:0] en_req_aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]   en_req_id_i,
  input  logic                         ws_req_valid_i,
  input  logic [fsync_pkg::AGGR_W-1:0] ws_req_aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]   ws_req_id_i,
  input  logic                         up_rsp_valid_i,
  input  logic [fsync_pkg::ID_W-1:0]   up_rsp_id_i,
  output logic                         up_req_valid_o,
  output logic [fsync_pkg::AGGR_W-1:0] up_req_aggr_o,
  output logic [fsync_pkg::ID_W-1:0]   up_req_id_o,
  output logic                         rsp_valid_o,
  output logic [fsync_pkg::ID_W-1:0]   rsp_id_o,
  output logic                         error_o
);

  logic                         en_empty;
  logic [fsync_pkg::AGGR_W-1:0] en_aggr;
  logic [fsync_pkg::ID_W-1:0]   en_id;
  logic                         en_pop;
  logic                         en_overflow;
  logic                         ws_empty;
  logic [fsync_pkg::AGGR_W-1:0] ws_aggr;
  logic [fsync_pkg::ID_W-1:0]   ws_id;
  logic                         ws_pop;
  logic                         ws_overflow;
  logic                         arb_valid;
  fsync_pkg::child_e            arb_src;
  logic [fsync_pkg::AGGR_W-1:0] arb_aggr;
  logic [fsync_pkg::ID_W-1:0]   arb_id;
  logic                         local_valid;
  logic [fsync_pkg::ID_W-1:0]   local_id;
  logic                         rsp_overflow;

  fsync_rx u_rx_en (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (en_req_valid_i),
    .req_aggr_i  (en_req_aggr_i),
    .req_id_i    (en_req_id_i),
    .pop_i       (en_pop),
    .empty_o     (en_empty),
    .aggr_o      (en_aggr),
    .id_o        (en_id),
    .overflow_o  (en_overflow)
  );

  fsync_rx u_rx_ws (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (ws_req_valid_i),
    .req_aggr_i  (ws_req_aggr_i),
    .req_id_i    (ws_req_id_i),
    .pop_i       (ws_pop),
    .empty_o     (ws_empty),
    .aggr_o      (ws_aggr),
    .id_o        (ws_id),
    .overflow_o  (ws_overflow)
  );

  fsync_req_arb u_req_arb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_empty_i (en_empty),
    .en_aggr_i  (en_aggr),
    .en_id_i    (en_id),
    .ws_empty_i (ws_empty),
    .ws_aggr_i  (ws_aggr),
    .ws_id_i    (ws_id),
    .en_pop_o   (en_pop),
    .ws_pop_o   (ws_pop),
    .valid_o    (arb_valid),
    .src_o      (arb_src),
    .aggr_o     (arb_aggr),
    .id_o       (arb_id)
  );

  // bit 1 carries the ws side, matching CHILD_WS.
  fsync_barrier u_barrier (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .valid_i        (arb_valid),
    .src_i          (arb_src),
    .aggr_i         (arb_aggr),
    .id_i           (arb_id),
    .rx_overflow_i  ({ws_overflow, en_overflow}),
    .rsp_overflow_i (rsp_overflow),
    .up_req_valid_o (up_req_valid_o),
    .up_req_aggr_o  (up_req_aggr_o),
    .up_req_id_o    (up_req_id_o),
    .local_valid_o  (local_valid),
    .local_id_o     (local_id),
    .error_o        (error_o)
  );

  fsync_rsp_merge u_rsp_merge (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .local_valid_i  (local_valid),
    .local_id_i     (local_id),
    .up_rsp_valid_i (up_rsp_valid_i),
    .up_rsp_id_i    (up_rsp_id_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_id_o       (rsp_id_o),
    .overflow_o     (rsp_overflow)
  );

endmodule

// ==== logic/fsync_pkg.sv ====
package fsync_pkg;

  // width of the aggregate mask carried with each barrier request.
  localparam int unsigned AGGR_W = 4;

  // barrier id width and the number of entries in the arrival table.
  localparam int unsigned ID_W  = 4;
  localparam int unsigned N_IDS = 1 << ID_W;

  // entries per FIFO; must stay a power of two so the pointers wrap on their own.
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned PTR_W      = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W      = $clog2(FIFO_DEPTH + 1);

  // fill level at which a FIFO refuses a new entry.
  localparam logic [CNT_W-1:0] FIFO_FULL = CNT_W'(FIFO_DEPTH);

  // an aggregate mask of one means the barrier closes at this node.
  localparam logic [AGGR_W-1:0] AGGR_LOCAL = AGGR_W'(1);

  // the two child sides of the node.
  typedef enum logic {
    CHILD_EN,
    CHILD_WS
  } child_e;

  // where a completed barrier is resolved.
  typedef enum logic {
    SYNC_LOCAL,
    SYNC_REMOTE
  } sync_kind_e;

endpackage

// ==== logic/fsync_req_arb.sv ====
`timescale 1ns/1ps

module fsync_req_arb (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         en_empty_i,
  input  logic [fsync_pkg::AGGR_W-1:0] en_aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]   en_id_i,
  input  logic                         ws_empty_i,
  input  logic [fsync_pkg::AGGR_W-1:0] ws_aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]   ws_id_i,
  output logic                         en_pop_o,
  output logic                         ws_pop_o,
  output logic                         valid_o,
  output fsync_pkg::child_e            src_o,
  output logic [fsync_pkg::AGGR_W-1:0] aggr_o,
  output logic [fsync_pkg::ID_W-1:0]   id_o
);

  fsync_pkg::child_e last_q;
  fsync_pkg::child_e grant;

  // with both sides waiting, the side that was not served last wins.
  always_comb begin
    if (!en_empty_i && !ws_empty_i) begin
      grant = (last_q == fsync_pkg::CHILD_EN) ? fsync_pkg::CHILD_WS : fsync_pkg::CHILD_EN;
    end else if (!ws_empty_i) begin
      grant = fsync_pkg::CHILD_WS;
    end else begin
      grant = fsync_pkg::CHILD_EN;
    end
  end

  assign valid_o  = !en_empty_i || !ws_empty_i;
  assign src_o    = grant;
  assign en_pop_o = valid_o && (grant == fsync_pkg::CHILD_EN);
  assign ws_pop_o = valid_o && (grant == fsync_pkg::CHILD_WS);
  assign aggr_o   = (grant == fsync_pkg::CHILD_WS) ? ws_aggr_i : en_aggr_i;
  assign id_o     = (grant == fsync_pkg::CHILD_WS) ? ws_id_i : en_id_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= fsync_pkg::CHILD_WS;
    end else if (valid_o) begin
      last_q <= grant;
    end
  end

endmodule

// ==== logic/fsync_rsp_merge.sv ====
`timescale 1ns/1ps

module fsync_rsp_merge (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       local_valid_i,
  input  logic [fsync_pkg::ID_W-1:0] local_id_i,
  input  logic                       up_rsp_valid_i,
  input  logic [fsync_pkg::ID_W-1:0] up_rsp_id_i,
  output logic                       rsp_valid_o,
  output logic [fsync_pkg::ID_W-1:0] rsp_id_o,
  output logic                       overflow_o
);

  logic [fsync_pkg::ID_W-1:0]  mem_q [fsync_pkg::FIFO_DEPTH];
  logic [fsync_pkg::PTR_W-1:0] wr_ptr_q;
  logic [fsync_pkg::PTR_W-1:0] rd_ptr_q;
  logic [fsync_pkg::CNT_W-1:0] count_q;
  logic                        empty;
  logic                        full;
  logic                        push;
  logic                        pop;
  logic                        rsp_valid_q;
  logic [fsync_pkg::ID_W-1:0]  rsp_id_q;

  assign empty = (count_q == '0);
  assign full  = (count_q == fsync_pkg::FIFO_FULL);

  // local completions take the output slot, and queued parent responses wait.
  assign pop        = !local_valid_i && !empty;
  assign push       = up_rsp_valid_i && (!full || pop);
  assign overflow_o = up_rsp_valid_i && full && !pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      rsp_valid_q <= local_valid_i || pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= up_rsp_id_i;
    end
    rsp_id_q <= local_valid_i ? local_id_i : mem_q[rd_ptr_q];
  end

  // one response goes to both children at once.
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_id_o    = rsp_id_q;

endmodule

// ==== logic/fsync_rx.sv ====
`timescale 1ns/1ps

module fsync_rx (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_valid_i,
  input  logic [fsync_pkg::AGGR_W-1:0] req_aggr_i,
  input  logic [fsync_pkg::ID_W-1:0]   req_id_i,
  input  logic                         pop_i,
  output logic                         empty_o,
  output logic [fsync_pkg::AGGR_W-1:0] aggr_o,
  output logic [fsync_pkg::ID_W-1:0]   id_o,
  output logic                         overflow_o
);

  logic [fsync_pkg::AGGR_W-1:0] aggr_mem_q [fsync_pkg::FIFO_DEPTH];
  logic [fsync_pkg::ID_W-1:0]   id_mem_q [fsync_pkg::FIFO_DEPTH];
  logic [fsync_pkg::PTR_W-1:0]  wr_ptr_q;
  logic [fsync_pkg::PTR_W-1:0]  rd_ptr_q;
  logic [fsync_pkg::CNT_W-1:0]  count_q;
  logic                         full;
  logic                         push;
  logic                         pop;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == fsync_pkg::FIFO_FULL);

  // a pop in the same cycle frees a slot, so a full FIFO can still take the strobe.
  assign pop        = pop_i && !empty_o;
  assign push       = req_valid_i && (!full || pop);
  assign overflow_o = req_valid_i && full && !pop;

  assign aggr_o = aggr_mem_q[rd_ptr_q];
  assign id_o   = id_mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // the strobe is written straight into the FIFO, so it is visible right after the edge.
  always_ff @(posedge clk_i) begin
    if (push) begin
      aggr_mem_q[wr_ptr_q] <= req_aggr_i;
      id_mem_q[wr_ptr_q]   <= req_id_i;
    end
  end

endmodule
